// ==== bank_htu.f ====
htu_pkg.sv
htu_set_entry.sv
htu_lookup.sv
bank_htu_top.sv
bank_htu_props.sv
tb_bank_htu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_bank_htu
FLIST     ?= bank_htu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_bank_htu.sv ====
`timescale 1ns/1ps

module tb_bank_htu;

  import htu_pkg::*;

  typedef struct packed {
    op_e               op;
    logic [addr_w-1:0] addr;
    logic              isu_rdy;
    logic              ar_rdy;
    logic              aw_rdy;
  } stim_row_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              req_valid_i;
  htu_req_t          req_i;
  logic              req_allow_o;
  logic              isu_valid_o;
  logic              isu_ready_i;
  isu_req_t          isu_o;
  logic              ar_valid_o;
  logic              ar_ready_i;
  logic [line_w-1:0] ar_addr_o;
  logic              aw_valid_o;
  logic              aw_ready_i;
  logic [line_w-1:0] aw_addr_o;

  // reference model of every set
  logic             ref_valid [num_sets][num_ways];
  logic [tag_w-1:0] ref_tag   [num_sets][num_ways];
  half_state_e      ref_st0   [num_sets][num_ways];
  half_state_e      ref_st1   [num_sets][num_ways];
  logic [way_w-1:0] ref_ptr   [num_sets];

  stim_row_t        stim_q[$];
  int unsigned      err_cnt;
  int unsigned      check_cnt;
  int unsigned      prop_errs;
  int unsigned      cycle_cnt = 0;
  int unsigned      cycle_limit = 1000;
  int               i;
  int               s;
  int               w;
  logic [tag_w-1:0] tag_a;
  logic [tag_w-1:0] tag_b;
  logic [tag_w-1:0] tag_c;

  bank_htu_top dut (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_valid_i (req_valid_i),
    .req_i       (req_i      ),
    .req_allow_o (req_allow_o),
    .isu_valid_o (isu_valid_o),
    .isu_ready_i (isu_ready_i),
    .isu_o       (isu_o      ),
    .ar_valid_o  (ar_valid_o ),
    .ar_ready_i  (ar_ready_i ),
    .ar_addr_o   (ar_addr_o  ),
    .aw_valid_o  (aw_valid_o ),
    .aw_ready_i  (aw_ready_i ),
    .aw_addr_o   (aw_addr_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: stimulus still running after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
                                                  input logic [set_w-1:0] set,
                                                  input logic off);
    return {tag, 2'b10, set, off, 4'h0};
  endfunction

  function automatic logic [tag_w-1:0] filler_tag();
    logic [31:0] rnd;
    rnd = $urandom();
    // top tag bit set keeps fillers apart from the named lines
    return {1'b1, rnd[tag_w-2:0]};
  endfunction

  task automatic add_row(input op_e op, input logic [addr_w-1:0] addr,
                         input logic isu_rdy, input logic ar_rdy, input logic aw_rdy);
    stim_q.push_back('{op, addr, isu_rdy, ar_rdy, aw_rdy});
  endtask

  task automatic compare_field(input string ctx, input string name,
                               input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s: %s got 0x%0h expected 0x%0h", ctx, name, got, exp);
    end
  endtask

  task automatic update_model(input op_e op, input logic [set_w-1:0] set,
                              input logic [tag_w-1:0] tag, input logic off,
                              input logic hit, input logic [way_w-1:0] way);
    half_state_e fill;
    fill = (op == OP_WRITE) ? ST_DIRTY : ST_CLEAN;
    if ((op == OP_READ || op == OP_WRITE) && !hit) begin
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way]   = tag;
      ref_st0[set][way]   = off ? ST_EMPTY : fill;
      ref_st1[set][way]   = off ? fill : ST_EMPTY;
      ref_ptr[set]        = ref_ptr[set] + way_w'(1);
    end else if (op == OP_READ || op == OP_WRITE) begin
      // read hit only fills an empty half
      if (off) begin
        if (op == OP_WRITE || ref_st1[set][way] == ST_EMPTY) begin
          ref_st1[set][way] = fill;
        end
      end else if (op == OP_WRITE || ref_st0[set][way] == ST_EMPTY) begin
        ref_st0[set][way] = fill;
      end
    end else if (op == OP_INVAL && hit) begin
      ref_valid[set][way] = 1'b0;
      ref_st0[set][way]   = ST_EMPTY;
      ref_st1[set][way]   = ST_EMPTY;
    end
  endtask

  task automatic apply_row(input int idx);
    stim_row_t        r;
    htu_req_t         req;
    isu_req_t         exp_isu;
    string            ctx;
    logic             hit;
    logic [way_w-1:0] way;
    half_state_e      s0;
    half_state_e      s1;
    logic             refill;
    logic             evict;
    logic             bus_ok;
    logic             allow;
    int               k;
    r            = stim_q[idx];
    ctx          = $sformatf("row %0d", idx);
    req.ch_id    = idx[1:0];
    req.op       = r.op;
    req.tag      = r.addr[31:10];
    req.line_mid = r.addr[9:8];
    req.set      = r.addr[7:5];
    req.offset   = r.addr[4];
    req.wbuf_id  = idx[7:0] ^ 8'h5a;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    isu_ready_i <= r.isu_rdy;
    ar_ready_i  <= r.ar_rdy;
    aw_ready_i  <= r.aw_rdy;
    // expected answer from the model before this request
    hit = 1'b0;
    way = ref_ptr[req.set];
    for (k = 0; k < num_ways; k++) begin
      if (ref_valid[req.set][k] && ref_tag[req.set][k] == req.tag) begin
        hit = 1'b1;
        way = k[way_w-1:0];
      end
    end
    s0      = hit ? ref_st0[req.set][way] : ST_EMPTY;
    s1      = hit ? ref_st1[req.set][way] : ST_EMPTY;
    refill  = (r.op == OP_READ) && ((req.offset[0] ? s1 : s0) == ST_EMPTY);
    evict   = (r.op == OP_READ || r.op == OP_WRITE) && !hit && ref_valid[req.set][way] &&
              (ref_st0[req.set][way] == ST_DIRTY || ref_st1[req.set][way] == ST_DIRTY);
    bus_ok  = (!refill || r.ar_rdy) && (!evict || r.aw_rdy);
    allow   = bus_ok && r.isu_rdy;
    exp_isu = '{ch_id: req.ch_id, write: r.op == OP_WRITE, evict: evict, set: req.set,
                way: way, offset: req.offset, wbuf_id: req.wbuf_id,
                off0_state: s0, off1_state: s1};
    @(negedge clk_i);
    compare_field(ctx, "req_allow_o", req_allow_o, allow);
    compare_field(ctx, "isu_valid_o", isu_valid_o, bus_ok);
    compare_field(ctx, "ar_valid_o", ar_valid_o, allow && refill);
    compare_field(ctx, "aw_valid_o", aw_valid_o, allow && evict);
    compare_field(ctx, "ar_addr_o", ar_addr_o, r.addr[31:5]);
    if (bus_ok) begin
      compare_field(ctx, "isu_o", isu_o, exp_isu);
    end
    if (allow && evict) begin
      compare_field(ctx, "aw_addr_o", aw_addr_o,
                    {ref_tag[req.set][way], {mid_w{1'b0}}, req.set});
    end
    if (allow) begin
      update_model(r.op, req.set, req.tag, req.offset[0], hit, way);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'hd026b2e0));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    isu_ready_i = 1'b0;
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    for (s = 0; s < num_sets; s++) begin
      ref_ptr[s] = '0;
      for (w = 0; w < num_ways; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
        ref_st0[s][w]   = ST_EMPTY;
        ref_st1[s][w]   = ST_EMPTY;
      end
    end
    tag_a = 22'h0a5a5;
    tag_b = 22'h01234;
    tag_c = '0;

    // first access, repeat, then the other half
    add_row(OP_READ,  make_addr(tag_b, 3'd0, 1'b1), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_a, 3'd2, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_a, 3'd2, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_a, 3'd2, 1'b1), 1'b1, 1'b1, 1'b1);
    add_row(OP_WRITE, make_addr(tag_a, 3'd2, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_a, 3'd2, 1'b0), 1'b1, 1'b1, 1'b1);
    // stalled refill in set 3, then the retry
    add_row(OP_READ,  make_addr(tag_b, 3'd3, 1'b0), 1'b1, 1'b0, 1'b1);
    add_row(OP_READ,  make_addr(tag_b, 3'd3, 1'b0), 1'b0, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_b, 3'd3, 1'b0), 1'b1, 1'b1, 1'b1);
    // wrap the set 2 pointer back to the dirty way
    for (i = 0; i < 7; i++) begin
      add_row(OP_READ, make_addr(filler_tag(), 3'd2, i[0]), 1'b1, 1'b1, 1'b1);
    end
    tag_c = filler_tag();
    add_row(OP_READ,  make_addr(tag_c, 3'd2, 1'b0), 1'b1, 1'b1, 1'b0);
    add_row(OP_READ,  make_addr(tag_c, 3'd2, 1'b0), 1'b1, 1'b1, 1'b1);
    // invalidate hit, reallocation, invalidate miss
    add_row(OP_INVAL, make_addr(tag_b, 3'd3, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_b, 3'd3, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_INVAL, make_addr(filler_tag(), 3'd3, 1'b1), 1'b1, 1'b1, 1'b1);
    // flush passes through and leaves the line in place
    add_row(OP_FLUSH, make_addr(tag_c, 3'd2, 1'b1), 1'b1, 1'b1, 1'b1);
    add_row(OP_FLUSH, make_addr(filler_tag(), 3'd6, 1'b0), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_c, 3'd2, 1'b1), 1'b1, 1'b1, 1'b1);
    // write miss allocates dirty
    add_row(OP_WRITE, make_addr(tag_a, 3'd5, 1'b1), 1'b1, 1'b1, 1'b1);
    add_row(OP_READ,  make_addr(tag_a, 3'd5, 1'b1), 1'b1, 1'b1, 1'b1);
    cycle_limit = stim_q.size() * 4 + 50;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare_field("reset", "req_allow_o", req_allow_o, 1'b0);
    compare_field("reset", "isu_valid_o", isu_valid_o, 1'b0);
    compare_field("reset", "ar_valid_o", ar_valid_o, 1'b0);
    compare_field("reset", "aw_valid_o", aw_valid_o, 1'b0);
    @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (i = 0; i < stim_q.size(); i++) begin
      apply_row(i);
    end

    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    compare_field("idle", "req_allow_o", req_allow_o, 1'b0);
    compare_field("idle", "isu_valid_o", isu_valid_o, 1'b0);
    prop_errs = dut.u_props.ar_fail_cnt + dut.u_props.aw_fail_cnt +
                dut.u_props.rst_fail_cnt;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             check_cnt, err_cnt, prop_errs);
    if (err_cnt == 0 && prop_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== bank_htu_props.sv ====
`timescale 1ns/1ps

module bank_htu_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_allow_o,
  input logic isu_valid_o,
  input logic ar_valid_o,
  input logic aw_valid_o
);

  int unsigned ar_fail_cnt = 0;
  int unsigned aw_fail_cnt = 0;
  int unsigned rst_fail_cnt = 0;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  // a refill always rides on an issued request
  ar_with_isu: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ar_valid_o |-> isu_valid_o
  ) else begin
    ar_fail_cnt++;
    $error("ar_valid_o high while isu_valid_o is low");
  end

  // eviction only with an accepted request
  aw_with_allow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) aw_valid_o |-> req_allow_o
  ) else begin
    aw_fail_cnt++;
    $error("aw_valid_o high while req_allow_o is low");
  end

  // --------------------------------------------------
  // reset
  // --------------------------------------------------
  quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !(req_allow_o || isu_valid_o || ar_valid_o || aw_valid_o)
  ) else begin
    rst_fail_cnt++;
    $error("valid output high during reset");
  end

endmodule

bind bank_htu_top bank_htu_props u_props (
  .clk_i       (clk_i      ),
  .rst_n_i     (rst_n_i    ),
  .req_allow_o (req_allow_o),
  .isu_valid_o (isu_valid_o),
  .ar_valid_o  (ar_valid_o ),
  .aw_valid_o  (aw_valid_o )
);

// ==== bank_htu_top.sv ====
`timescale 1ns/1ps

module bank_htu_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // request in
  input  logic                         req_valid_i,
  input  htu_pkg::htu_req_t            req_i,
  output logic                         req_allow_o,
  // issue unit
  output logic                         isu_valid_o,
  input  logic                         isu_ready_i,
  output htu_pkg::isu_req_t            isu_o,
  // bus read address
  output logic                         ar_valid_o,
  input  logic                         ar_ready_i,
  output logic [htu_pkg::line_w-1:0]   ar_addr_o,
  // bus write address
  output logic                         aw_valid_o,
  input  logic                         aw_ready_i,
  output logic [htu_pkg::line_w-1:0]   aw_addr_o
);

  import htu_pkg::*;

  logic [num_sets-1:0]        set_sel;
  set_lookup_t [num_sets-1:0] set_lookup;

  // --------------------------------------------------
  // set array
  // --------------------------------------------------
  for (genvar s = 0; s < num_sets; s++) begin : g_set
    htu_set_entry u_set_entry (
      .clk_i    (clk_i        ),
      .rst_n_i  (rst_n_i      ),
      .sel_i    (set_sel[s]   ),
      .req_i    (req_i        ),
      .lookup_o (set_lookup[s])
    );
  end

  // --------------------------------------------------
  // select and handshake
  // --------------------------------------------------
  htu_lookup u_lookup (
    .req_valid_i (req_valid_i),
    .req_i       (req_i      ),
    .req_allow_o (req_allow_o),
    .set_sel_o   (set_sel    ),
    .sets_i      (set_lookup ),
    .isu_valid_o (isu_valid_o),
    .isu_ready_i (isu_ready_i),
    .isu_o       (isu_o      ),
    .ar_valid_o  (ar_valid_o ),
    .ar_ready_i  (ar_ready_i ),
    .ar_addr_o   (ar_addr_o  ),
    .aw_valid_o  (aw_valid_o ),
    .aw_ready_i  (aw_ready_i ),
    .aw_addr_o   (aw_addr_o  )
  );

endmodule

// ==== htu_lookup.sv ====
`timescale 1ns/1ps

module htu_lookup (
  input  logic                                       req_valid_i,
  input  htu_pkg::htu_req_t                          req_i,
  output logic                                       req_allow_o,
  output logic [htu_pkg::num_sets-1:0]               set_sel_o,
  input  htu_pkg::set_lookup_t [htu_pkg::num_sets-1:0] sets_i,
  output logic                                       isu_valid_o,
  input  logic                                       isu_ready_i,
  output htu_pkg::isu_req_t                          isu_o,
  output logic                                       ar_valid_o,
  input  logic                                       ar_ready_i,
  output logic [htu_pkg::line_w-1:0]                 ar_addr_o,
  output logic                                       aw_valid_o,
  input  logic                                       aw_ready_i,
  output logic [htu_pkg::line_w-1:0]                 aw_addr_o
);

  import htu_pkg::*;

  set_lookup_t cur_set;
  logic        need_refill;
  logic        need_evict;
  logic        bus_ok;
  logic        kickoff;

  // --------------------------------------------------
  // set select
  // --------------------------------------------------
  assign cur_set     = sets_i[req_i.set];
  assign need_refill = cur_set.need_refill;
  assign need_evict  = cur_set.need_evict;

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  // every needed bus channel must take its request too
  assign bus_ok = (!need_refill || ar_ready_i) && (!need_evict || aw_ready_i);

  assign req_allow_o = req_valid_i && isu_ready_i && bus_ok;
  assign isu_valid_o = req_valid_i && bus_ok;
  assign kickoff     = req_valid_i && req_allow_o;

  // one-hot write enable, only on an accepted request
  always_comb begin
    set_sel_o = '0;
    if (kickoff) begin
      set_sel_o[req_i.set] = 1'b1;
    end
  end

  // --------------------------------------------------
  // issue request
  // --------------------------------------------------
  always_comb begin
    isu_o            = '0;
    isu_o.ch_id      = req_i.ch_id;
    isu_o.write      = req_i.op == OP_WRITE;
    isu_o.evict      = need_evict;
    isu_o.set        = req_i.set;
    isu_o.way        = cur_set.way;
    isu_o.offset     = req_i.offset;
    isu_o.wbuf_id    = req_i.wbuf_id;
    isu_o.off0_state = cur_set.off0_state;
    isu_o.off1_state = cur_set.off1_state;
  end

  // --------------------------------------------------
  // bus requests
  // --------------------------------------------------
  assign ar_valid_o = kickoff && need_refill;
  assign aw_valid_o = kickoff && need_evict;

  assign ar_addr_o = {req_i.tag, req_i.line_mid, req_i.set};

  // old line rebuilt from its tag, bits 9:8 are not kept
  assign aw_addr_o = {cur_set.evict_tag, {mid_w{1'b0}}, req_i.set};

endmodule

// ==== htu_set_entry.sv ====
`timescale 1ns/1ps

module htu_set_entry (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sel_i,
  input  htu_pkg::htu_req_t    req_i,
  output htu_pkg::set_lookup_t lookup_o
);

  import htu_pkg::*;

  // per-way storage
  logic [num_ways-1:0] valid_q;
  logic [tag_w-1:0]    tag_q  [num_ways];
  half_state_e         off0_q [num_ways];
  half_state_e         off1_q [num_ways];
  logic [way_w-1:0]    ptr_q;

  logic [num_ways-1:0] hit_vec;
  logic                hit;
  logic [way_w-1:0]    hit_way;
  logic [way_w-1:0]    acc_way;
  logic                op_rd;
  logic                op_wr;
  logic                alloc;
  logic                victim_dirty;
  logic                need_evict;
  half_state_e         cur_off0;
  half_state_e         cur_off1;
  half_state_e         cur_half;
  half_state_e         new_half;
  half_state_e         hit_half_nxt;

  // --------------------------------------------------
  // tag compare
  // --------------------------------------------------
  assign op_rd = req_i.op == OP_READ;
  assign op_wr = req_i.op == OP_WRITE;

  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    for (int i = 0; i < num_ways; i++) begin
      hit_vec[i] = valid_q[i] && (tag_q[i] == req_i.tag);
      if (hit_vec[i]) begin
        hit_way = way_w'(i);
      end
    end
  end

  assign hit     = |hit_vec;
  // victim pointer names the way on a miss
  assign acc_way = hit ? hit_way : ptr_q;

  // a missing line reports as empty
  assign cur_off0 = hit ? off0_q[hit_way] : ST_EMPTY;
  assign cur_off1 = hit ? off1_q[hit_way] : ST_EMPTY;
  assign cur_half = req_i.offset[0] ? cur_off1 : cur_off0;

  assign alloc        = (op_rd || op_wr) && !hit;
  assign victim_dirty = (off0_q[ptr_q] == ST_DIRTY) || (off1_q[ptr_q] == ST_DIRTY);
  assign need_evict   = alloc && valid_q[ptr_q] && victim_dirty;

  always_comb begin
    lookup_o             = '0;
    lookup_o.hit         = hit;
    lookup_o.way         = acc_way;
    lookup_o.off0_state  = cur_off0;
    lookup_o.off1_state  = cur_off1;
    lookup_o.need_refill = op_rd && (cur_half == ST_EMPTY);
    lookup_o.need_evict  = need_evict;
    lookup_o.evict_tag   = need_evict ? tag_q[ptr_q] : '0;
  end

  // --------------------------------------------------
  // state update
  // --------------------------------------------------
  assign new_half = op_wr ? ST_DIRTY : ST_CLEAN;

  // read hit only fills an empty half, write always dirties it
  always_comb begin
    if (op_wr) begin
      hit_half_nxt = ST_DIRTY;
    end else if (cur_half == ST_EMPTY) begin
      hit_half_nxt = ST_CLEAN;
    end else begin
      hit_half_nxt = cur_half;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      ptr_q   <= '0;
      for (int i = 0; i < num_ways; i++) begin
        off0_q[i] <= ST_EMPTY;
        off1_q[i] <= ST_EMPTY;
      end
    end else if (sel_i) begin
      case (req_i.op)
        OP_READ, OP_WRITE: begin
          if (alloc) begin
            valid_q[ptr_q] <= 1'b1;
            off0_q[ptr_q]  <= req_i.offset[0] ? ST_EMPTY : new_half;
            off1_q[ptr_q]  <= req_i.offset[0] ? new_half : ST_EMPTY;
            ptr_q          <= ptr_q + 1'b1;
          end else if (req_i.offset[0]) begin
            off1_q[hit_way] <= hit_half_nxt;
          end else begin
            off0_q[hit_way] <= hit_half_nxt;
          end
        end
        OP_INVAL: begin
          if (hit) begin
            valid_q[hit_way] <= 1'b0;
            off0_q[hit_way]  <= ST_EMPTY;
            off1_q[hit_way]  <= ST_EMPTY;
          end
        end
        // flush leaves the set alone
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && alloc) begin
      tag_q[ptr_q] <= req_i.tag;
    end
  end

endmodule

// ==== htu_pkg.sv ====
package htu_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int addr_w   = 32;
  // line address, bits 31:5
  localparam int line_w   = addr_w - 5;
  // tag, bits 31:10
  localparam int tag_w    = addr_w - 10;
  localparam int num_sets = 8;
  // set index, bits 7:5
  localparam int set_w    = $clog2(num_sets);
  localparam int num_ways = 8;
  localparam int way_w    = $clog2(num_ways);
  // half-line select, bit 4
  localparam int offset_w = 1;
  // bits 9:8 sit in the line address but in neither tag nor set
  localparam int mid_w    = line_w - tag_w - set_w;
  localparam int ch_w     = 2;
  localparam int wbuf_w   = 8;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLUSH = 2'd2,
    OP_INVAL = 2'd3
  } op_e;

  typedef enum logic [1:0] {
    ST_EMPTY = 2'd0,
    ST_CLEAN = 2'd1,
    ST_DIRTY = 2'd2
  } half_state_e;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------
  typedef struct packed {
    logic [ch_w-1:0]     ch_id;
    op_e                 op;
    logic [tag_w-1:0]    tag;
    logic [mid_w-1:0]    line_mid;
    logic [set_w-1:0]    set;
    logic [offset_w-1:0] offset;
    logic [wbuf_w-1:0]   wbuf_id;
  } htu_req_t;

  typedef struct packed {
    logic             hit;
    logic [way_w-1:0] way;
    half_state_e      off0_state;
    half_state_e      off1_state;
    logic             need_refill;
    logic             need_evict;
    logic [tag_w-1:0] evict_tag;
  } set_lookup_t;

  typedef struct packed {
    logic [ch_w-1:0]     ch_id;
    logic                write;
    logic                evict;
    logic [set_w-1:0]    set;
    logic [way_w-1:0]    way;
    logic [offset_w-1:0] offset;
    logic [wbuf_w-1:0]   wbuf_id;
    half_state_e         off0_state;
    half_state_e         off1_state;
  } isu_req_t;

endpackage
